// File: sim.f
src/fractal_pkg.sv
src/mandel_core.sv
src/axil_regs.sv
src/pixel_walker.sv
src/core_dispatch.sv
src/stream_out.sv
src/pixel_generator.sv
+incdir+tests
tests/tb_pixel_generator.sv

// File: src/axil_regs.sv
// axi-lite configuration registers
`default_nettype none

module axil_regs #(
    parameter int AXIL_ADDR_WIDTH = 8
) (
    input  wire logic                       out_stream_aclk,
    input  wire logic                       axi_resetn,
    input  wire logic [AXIL_ADDR_WIDTH-1:0] awaddr_i,
    input  wire logic                       awvalid_i,
    output logic                            awready_o,
    input  wire logic [31:0]                wdata_i,
    input  wire logic                       wvalid_i,
    output logic                            wready_o,
    output logic [1:0]                      bresp_o,
    output logic                            bvalid_o,
    input  wire logic                       bready_i,
    input  wire logic [AXIL_ADDR_WIDTH-1:0] araddr_i,
    input  wire logic                       arvalid_i,
    output logic                            arready_o,
    output logic [31:0]                     rdata_o,
    output logic [1:0]                      rresp_o,
    output logic                            rvalid_o,
    input  wire logic                       rready_i,
    output fractal_pkg::cfg_t               cfg_o
);

    typedef enum logic [2:0] {W_IDLE, W_WAIT_DATA, W_WAIT_ADDR, W_WRITE, W_RESP} wr_state_t;
    typedef enum logic [1:0] {R_IDLE, R_FETCH, R_DATA} rd_state_t;

    wr_state_t   wr_state;
    rd_state_t   rd_state;
    logic [31:0] regs [fractal_pkg::REG_COUNT];
    logic [2:0]  wr_idx, rd_idx;
    logic        wr_ok, rd_ok;
    logic [31:0] wr_data, rd_data;

    // word index in [4:2], everything above must be zero
    function automatic logic addr_ok(input logic [AXIL_ADDR_WIDTH-1:0] addr);
        return ((addr >> 5) == '0) && (addr[4:2] < fractal_pkg::REG_COUNT);
    endfunction

    //////////////////////////////
    // write side

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            wr_state <= W_IDLE;
            for (int i = 0; i < fractal_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            case (wr_state)
                W_IDLE: begin
                    if (awvalid_i) begin
                        wr_idx <= awaddr_i[4:2];
                        wr_ok  <= addr_ok(awaddr_i);
                    end
                    if (wvalid_i) begin
                        wr_data <= wdata_i;
                    end
                    case ({awvalid_i, wvalid_i})
                        2'b11:   wr_state <= W_WRITE;
                        2'b10:   wr_state <= W_WAIT_DATA;
                        2'b01:   wr_state <= W_WAIT_ADDR;
                        default: wr_state <= W_IDLE;
                    endcase
                end
                W_WAIT_DATA: begin
                    if (wvalid_i) begin
                        wr_data  <= wdata_i;
                        wr_state <= W_WRITE;
                    end
                end
                W_WAIT_ADDR: begin
                    if (awvalid_i) begin
                        wr_idx   <= awaddr_i[4:2];
                        wr_ok    <= addr_ok(awaddr_i);
                        wr_state <= W_WRITE;
                    end
                end
                W_WRITE: begin
                    if (wr_ok) begin
                        regs[wr_idx] <= wr_data; // bad address dropped
                    end
                    wr_state <= W_RESP;
                end
                W_RESP: begin
                    if (bready_i) begin
                        wr_state <= W_IDLE;
                    end
                end
                default: wr_state <= W_IDLE;
            endcase
        end
    end

    assign awready_o = (wr_state == W_IDLE) || (wr_state == W_WAIT_ADDR);
    assign wready_o  = (wr_state == W_IDLE) || (wr_state == W_WAIT_DATA);
    assign bvalid_o  = (wr_state == W_RESP);
    assign bresp_o   = wr_ok ? fractal_pkg::RESP_OKAY : fractal_pkg::RESP_SLVERR;

    //////////////////////////////
    // read side

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            rd_state <= R_IDLE;
        end else begin
            case (rd_state)
                R_IDLE: begin
                    if (arvalid_i) begin
                        rd_idx   <= araddr_i[4:2];
                        rd_ok    <= addr_ok(araddr_i);
                        rd_state <= R_FETCH;
                    end
                end
                R_FETCH: begin
                    rd_data  <= rd_ok ? regs[rd_idx] : '0;
                    rd_state <= R_DATA;
                end
                R_DATA: begin
                    if (rready_i) begin
                        rd_state <= R_IDLE;
                    end
                end
                default: rd_state <= R_IDLE;
            endcase
        end
    end

    assign arready_o = (rd_state == R_IDLE);
    assign rvalid_o  = (rd_state == R_DATA);
    assign rdata_o   = rd_data;
    assign rresp_o   = rd_ok ? fractal_pkg::RESP_OKAY : fractal_pkg::RESP_SLVERR;

    always_comb begin
        cfg_o.start_x  = regs[fractal_pkg::REG_START_X];
        cfg_o.start_y  = regs[fractal_pkg::REG_START_Y];
        cfg_o.step     = regs[fractal_pkg::REG_STEP];
        cfg_o.max_iter = regs[fractal_pkg::REG_MAX_ITER][15:0];
        cfg_o.x_size   = regs[fractal_pkg::REG_SIZE][15:0];
        cfg_o.y_size   = regs[fractal_pkg::REG_SIZE][31:16];
        cfg_o.run      = regs[fractal_pkg::REG_CTRL][0];
    end

    state_legal_a: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        (wr_state inside {W_IDLE, W_WAIT_DATA, W_WAIT_ADDR, W_WRITE, W_RESP}) &&
        (rd_state inside {R_IDLE, R_FETCH, R_DATA}));

endmodule

`default_nettype wire

// File: src/core_dispatch.sv
// round-robin core dispatcher
`default_nettype none

module core_dispatch #(
    parameter int CORE_COUNT = 8
) (
    input  wire logic                 out_stream_aclk,
    input  wire logic                 axi_resetn,
    input  wire fractal_pkg::cfg_t    cfg_i,
    input  wire fractal_pkg::point_t  point_i,
    input  wire logic                 frame_start_i,
    input  wire logic                 out_ready_i,
    output logic                      next_o,
    output fractal_pkg::pixel_t       pix_o,
    output logic                      pix_valid_o
);

    localparam int PW = (CORE_COUNT > 1) ? $clog2(CORE_COUNT) : 1;

    logic [CORE_COUNT-1:0] active_q;  // slot holds an unsent job
    logic [CORE_COUNT-1:0] start_w, done_w;
    logic [CORE_COUNT-1:0] sof_q, eol_q;
    fractal_pkg::iter_t    iter_w [CORE_COUNT];
    fractal_pkg::iter_t    cur_iter;
    logic [PW-1:0]         ptr_q;
    logic                  can_issue, collect, issue;

    //////////////////////////////
    // issue and collect at the pointer

    // mid-frame points always go out, a new frame needs run
    assign can_issue = cfg_i.run || !frame_start_i;
    assign collect   = active_q[ptr_q] && done_w[ptr_q] && out_ready_i;
    assign issue     = can_issue && (!active_q[ptr_q] || collect);

    assign next_o      = issue;
    assign pix_valid_o = collect;
    assign start_w     = CORE_COUNT'(issue) << ptr_q;

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            ptr_q    <= '0;
            active_q <= '0;
        end else begin
            if (issue) begin
                active_q[ptr_q] <= 1'b1;
            end else if (collect) begin
                active_q[ptr_q] <= 1'b0;
            end
            // empty slots are stepped over toward the oldest job
            if (issue || collect || (!active_q[ptr_q] && (|active_q))) begin
                ptr_q <= (ptr_q == PW'(CORE_COUNT - 1)) ? '0 : ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge out_stream_aclk) begin
        if (issue) begin
            sof_q[ptr_q] <= point_i.sof;
            eol_q[ptr_q] <= point_i.eol;
        end
    end

    // color map
    assign cur_iter = iter_w[ptr_q];

    always_comb begin
        pix_o.r   = cur_iter[7:0];
        pix_o.g   = cur_iter[7:0];
        pix_o.b   = cur_iter[15:8];
        pix_o.sof = sof_q[ptr_q];
        pix_o.eol = eol_q[ptr_q];
    end

    for (genvar i = 0; i < CORE_COUNT; i++) begin : g_core
        mandel_core core_i (
            .out_stream_aclk (out_stream_aclk),
            .axi_resetn      (axi_resetn),
            .start_i         (start_w[i]),
            .c_i             (point_i),
            .max_iter_i      (cfg_i.max_iter),
            .iter_o          (iter_w[i]),
            .done_o          (done_w[i])
        );
    end

    no_push_when_full_a: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        pix_valid_o |-> out_ready_i);

endmodule

`default_nettype wire

// File: src/fractal_pkg.sv
// fractal generator shared types
`default_nettype none

package fractal_pkg;

    localparam int FRAC_BITS = 24; // signed Q8.24

    typedef logic signed [31:0] fixed_t;
    typedef logic [15:0] iter_t;

    //////////////////////////////
    // configuration and pixel data

    typedef struct packed {
        fixed_t      start_x;
        fixed_t      start_y;
        fixed_t      step;
        iter_t       max_iter;
        logic [15:0] x_size;
        logic [15:0] y_size;
        logic        run;
    } cfg_t;

    typedef struct packed {
        fixed_t re;
        fixed_t im;
        logic   sof;  // first pixel of frame
        logic   eol;  // last pixel of line
    } point_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic       sof;
        logic       eol;
    } pixel_t;

    //////////////////////////////
    // register map, word indices

    localparam int REG_CTRL     = 0;  // bit 0 run
    localparam int REG_START_X  = 1;
    localparam int REG_START_Y  = 2;
    localparam int REG_STEP     = 3;
    localparam int REG_MAX_ITER = 4;  // bits 15:0
    localparam int REG_SIZE     = 5;  // y_size in 31:16, x_size in 15:0
    localparam int REG_COUNT    = 6;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// File: src/mandel_core.sv
// mandelbrot escape-time core
`default_nettype none

module mandel_core (
    input  wire logic                 out_stream_aclk,
    input  wire logic                 axi_resetn,
    input  wire logic                 start_i,
    input  wire fractal_pkg::point_t  c_i,
    input  wire fractal_pkg::iter_t   max_iter_i,
    output fractal_pkg::iter_t        iter_o,
    output logic                      done_o
);

    localparam logic signed [32:0] ESC_LIMIT = 33'sd4 <<< fractal_pkg::FRAC_BITS;

    fractal_pkg::fixed_t zr_q, zi_q, cr_q, ci_q;
    fractal_pkg::fixed_t zr2, zi2, zri;
    fractal_pkg::iter_t  iter_q;
    logic                busy_q, done_q;
    logic signed [63:0]  zr_sq, zi_sq, zr_zi;
    logic signed [32:0]  mag;
    logic                escape;

    // full-width products, truncated back to Q8.24
    assign zr_sq = zr_q * zr_q;
    assign zi_sq = zi_q * zi_q;
    assign zr_zi = zr_q * zi_q;
    assign zr2   = fractal_pkg::fixed_t'(zr_sq >>> fractal_pkg::FRAC_BITS);
    assign zi2   = fractal_pkg::fixed_t'(zi_sq >>> fractal_pkg::FRAC_BITS);
    assign zri   = fractal_pkg::fixed_t'(zr_zi >>> (fractal_pkg::FRAC_BITS - 1)); // 2*zr*zi

    assign mag    = zr2 + zi2;
    assign escape = (mag > ESC_LIMIT) || (iter_q >= max_iter_i);

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (start_i) begin
            busy_q <= 1'b1;
            done_q <= 1'b0;
        end else if (busy_q && escape) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;  // held until next start
        end
    end

    always_ff @(posedge out_stream_aclk) begin
        if (start_i) begin
            zr_q   <= '0;
            zi_q   <= '0;
            cr_q   <= c_i.re;
            ci_q   <= c_i.im;
            iter_q <= '0;
        end else if (busy_q && !escape) begin
            zr_q   <= zr2 - zi2 + cr_q;
            zi_q   <= zri + ci_q;
            iter_q <= iter_q + 16'd1;
        end
    end

    assign iter_o = iter_q;
    assign done_o = done_q;

    iter_bound_a: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        $rose(done_o) |-> iter_o <= max_iter_i);

endmodule

`default_nettype wire

// File: src/pixel_generator.sv
// fractal pixel generator top
`default_nettype none

module pixel_generator #(
    parameter int CORE_COUNT      = 8,
    parameter int AXIL_ADDR_WIDTH = 8
) (
    input  wire logic                       out_stream_aclk,
    input  wire logic                       axi_resetn,

    input  wire logic [AXIL_ADDR_WIDTH-1:0] s_axi_lite_araddr_i,
    output logic                            s_axi_lite_arready_o,
    input  wire logic                       s_axi_lite_arvalid_i,
    input  wire logic [AXIL_ADDR_WIDTH-1:0] s_axi_lite_awaddr_i,
    output logic                            s_axi_lite_awready_o,
    input  wire logic                       s_axi_lite_awvalid_i,
    input  wire logic                       s_axi_lite_bready_i,
    output logic [1:0]                      s_axi_lite_bresp_o,
    output logic                            s_axi_lite_bvalid_o,
    output logic [31:0]                     s_axi_lite_rdata_o,
    input  wire logic                       s_axi_lite_rready_i,
    output logic [1:0]                      s_axi_lite_rresp_o,
    output logic                            s_axi_lite_rvalid_o,
    input  wire logic [31:0]                s_axi_lite_wdata_i,
    output logic                            s_axi_lite_wready_o,
    input  wire logic                       s_axi_lite_wvalid_i,

    output logic [31:0]                     out_stream_tdata_o,
    output logic [3:0]                      out_stream_tkeep_o,
    output logic                            out_stream_tlast_o,
    output logic                            out_stream_tuser_o,
    output logic                            out_stream_tvalid_o,
    input  wire logic                       out_stream_tready_i
);

    fractal_pkg::cfg_t   cfg;
    fractal_pkg::point_t point;
    fractal_pkg::pixel_t pix;
    logic                frame_start, next, pix_valid, out_ready;

    axil_regs #(.AXIL_ADDR_WIDTH(AXIL_ADDR_WIDTH)) regs_i (
        .out_stream_aclk (out_stream_aclk),
        .axi_resetn      (axi_resetn),
        .awaddr_i        (s_axi_lite_awaddr_i),
        .awvalid_i       (s_axi_lite_awvalid_i),
        .awready_o       (s_axi_lite_awready_o),
        .wdata_i         (s_axi_lite_wdata_i),
        .wvalid_i        (s_axi_lite_wvalid_i),
        .wready_o        (s_axi_lite_wready_o),
        .bresp_o         (s_axi_lite_bresp_o),
        .bvalid_o        (s_axi_lite_bvalid_o),
        .bready_i        (s_axi_lite_bready_i),
        .araddr_i        (s_axi_lite_araddr_i),
        .arvalid_i       (s_axi_lite_arvalid_i),
        .arready_o       (s_axi_lite_arready_o),
        .rdata_o         (s_axi_lite_rdata_o),
        .rresp_o         (s_axi_lite_rresp_o),
        .rvalid_o        (s_axi_lite_rvalid_o),
        .rready_i        (s_axi_lite_rready_i),
        .cfg_o           (cfg)
    );

    pixel_walker walker_i (
        .out_stream_aclk (out_stream_aclk),
        .axi_resetn      (axi_resetn),
        .cfg_i           (cfg),
        .next_i          (next),
        .point_o         (point),
        .frame_start_o   (frame_start)
    );

    core_dispatch #(.CORE_COUNT(CORE_COUNT)) dispatch_i (
        .out_stream_aclk (out_stream_aclk),
        .axi_resetn      (axi_resetn),
        .cfg_i           (cfg),
        .point_i         (point),
        .frame_start_i   (frame_start),
        .out_ready_i     (out_ready),
        .next_o          (next),
        .pix_o           (pix),
        .pix_valid_o     (pix_valid)
    );

    stream_out out_i (
        .out_stream_aclk (out_stream_aclk),
        .axi_resetn      (axi_resetn),
        .pix_i           (pix),
        .pix_valid_i     (pix_valid),
        .tready_i        (out_stream_tready_i),
        .ready_o         (out_ready),
        .tdata_o         (out_stream_tdata_o),
        .tkeep_o         (out_stream_tkeep_o),
        .tlast_o         (out_stream_tlast_o),
        .tuser_o         (out_stream_tuser_o),
        .tvalid_o        (out_stream_tvalid_o)
    );

endmodule

`default_nettype wire

// File: src/pixel_walker.sv
// raster coordinate walker
`default_nettype none

module pixel_walker (
    input  wire logic                 out_stream_aclk,
    input  wire logic                 axi_resetn,
    input  wire fractal_pkg::cfg_t    cfg_i,
    input  wire logic                 next_i,
    output fractal_pkg::point_t       point_o,
    output logic                      frame_start_o
);

    logic [15:0]         x_q, y_q;
    fractal_pkg::fixed_t re_acc_q, im_acc_q;
    logic                last_x, last_y;

    assign last_x        = (x_q == cfg_i.x_size - 16'd1);
    assign last_y        = (y_q == cfg_i.y_size - 16'd1);
    assign frame_start_o = (x_q == '0) && (y_q == '0);

    // column 0 and row 0 take the start values straight from config
    always_comb begin
        point_o.re  = (x_q == '0) ? cfg_i.start_x : re_acc_q;
        point_o.im  = (y_q == '0) ? cfg_i.start_y : im_acc_q;
        point_o.sof = frame_start_o;
        point_o.eol = last_x;
    end

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            x_q <= '0;
            y_q <= '0;
        end else if (next_i) begin
            if (last_x) begin
                x_q <= '0;
                y_q <= last_y ? 16'd0 : y_q + 16'd1;
            end else begin
                x_q <= x_q + 16'd1;
            end
        end
    end

    always_ff @(posedge out_stream_aclk) begin
        if (next_i) begin
            if (last_x) begin
                im_acc_q <= point_o.im - cfg_i.step;  // rows go down
            end else begin
                re_acc_q <= point_o.re + cfg_i.step;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/stream_out.sv
// axi-stream output stage
`default_nettype none

module stream_out (
    input  wire logic                 out_stream_aclk,
    input  wire logic                 axi_resetn,
    input  wire fractal_pkg::pixel_t  pix_i,
    input  wire logic                 pix_valid_i,
    input  wire logic                 tready_i,
    output logic                      ready_o,
    output logic [31:0]               tdata_o,
    output logic [3:0]                tkeep_o,
    output logic                      tlast_o,
    output logic                      tuser_o,
    output logic                      tvalid_o
);

    fractal_pkg::pixel_t beat_q;
    logic                valid_q;

    always_ff @(posedge out_stream_aclk) begin
        if (!axi_resetn) begin
            valid_q <= 1'b0;
        end else if (pix_valid_i) begin
            valid_q <= 1'b1;
        end else if (tready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge out_stream_aclk) begin
        if (pix_valid_i) begin
            beat_q <= pix_i;
        end
    end

    assign ready_o  = !valid_q;  // one beat deep
    assign tvalid_o = valid_q;
    assign tdata_o  = {8'h00, beat_q.r, beat_q.g, beat_q.b};
    assign tkeep_o  = 4'hf;
    assign tlast_o  = beat_q.eol;
    assign tuser_o  = beat_q.sof;

    beat_stable_a: assert property (@(posedge out_stream_aclk) disable iff (!axi_resetn)
        (tvalid_o && !tready_i) |=> (tvalid_o && $stable(tdata_o)));

endmodule

`default_nettype wire

// File: tests/tb_model.svh
// axi-lite driver and escape-time model
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

task automatic next_cycle();
    @(posedge out_stream_aclk);
    #2;
endtask

// order 0 sends address and data together, 1 address first, 2 data first
task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                         input int order, output logic [1:0] resp);
    logic aw_done, w_done, aw_hs, w_hs;
    aw_done = 1'b0;
    w_done  = 1'b0;
    awaddr  = addr;
    wdata   = data;
    while (!(aw_done && w_done)) begin
        awvalid = !aw_done && (order != 2 || w_done);
        wvalid  = !w_done && (order != 1 || aw_done);
        aw_hs   = awvalid && awready;  // ready only depends on state
        w_hs    = wvalid && wready;
        next_cycle();
        aw_done = aw_done || aw_hs;
        w_done  = w_done || w_hs;
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    while (!bvalid) begin
        next_cycle();
    end
    resp = bresp;
    next_cycle();
    bready = 1'b0;
endtask

task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                        output logic [1:0] resp);
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) begin
        next_cycle();
    end
    next_cycle();
    arvalid = 1'b0;
    rready  = 1'b1;
    while (!rvalid) begin
        next_cycle();
    end
    data = rdata;
    resp = rresp;
    next_cycle();
    rready = 1'b0;
endtask

// z starts at 0; squares truncated to Q8.24 before the magnitude test
function automatic int escape_count(input int cr, input int ci, input int max_iter);
    int     zr, zi, zr2, zi2, zri, n;
    longint mag;
    zr = 0;
    zi = 0;
    n  = 0;
    while (n < max_iter) begin
        zr2 = int'((longint'(zr) * longint'(zr)) >>> fractal_pkg::FRAC_BITS);
        zi2 = int'((longint'(zi) * longint'(zi)) >>> fractal_pkg::FRAC_BITS);
        zri = int'((longint'(zr) * longint'(zi)) >>> (fractal_pkg::FRAC_BITS - 1));
        mag = longint'(zr2) + longint'(zi2);
        if (mag > (longint'(4) <<< fractal_pkg::FRAC_BITS)) begin
            return n;
        end
        zr = zr2 - zi2 + cr;  // 32-bit wrap like the core
        zi = zri + ci;
        n++;
    end
    return n;
endfunction

`endif

// File: tests/tb_pixel_generator.sv
// fractal pixel generator testbench
`default_nettype none

module tb_pixel_generator;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          MAX_ITER     = 20;
    localparam int          FRAME_PIXELS = 12;  // 4 by 3
    localparam int          IDLE_WAIT    = 500;
    localparam logic [31:0] VIEW_X       = 32'hfe00_0000;  // -2.0
    localparam logic [31:0] VIEW_Y       = 32'h0100_0000;  // 1.0
    localparam logic [31:0] VIEW_STEP    = 32'h0099_999a;  // 0.6
    // two frames per single-frame run, three for the two-frame run
    localparam int          PIXELS_TOTAL = 84;
    localparam int          CYCLE_LIMIT  = PIXELS_TOTAL * (MAX_ITER + 4) + 2000;

    logic        out_stream_aclk, axi_resetn;
    logic [7:0]  araddr, awaddr;
    logic        arvalid, awvalid, bready, rready, wvalid, tready;
    logic [31:0] wdata, rdata, tdata;
    logic        arready, awready, bvalid, rvalid, wready;
    logic [1:0]  bresp, rresp;
    logic [3:0]  tkeep;
    logic        tlast, tuser, tvalid;

    logic [31:0] exp_data [FRAME_PIXELS];
    logic [31:0] reg_shadow [fractal_pkg::REG_COUNT];
    int          test_errors, tests_passed, tests_failed, cycle_count;

    pixel_generator #(.CORE_COUNT(8), .AXIL_ADDR_WIDTH(8)) dut_i (
        .out_stream_aclk      (out_stream_aclk),
        .axi_resetn           (axi_resetn),
        .s_axi_lite_araddr_i  (araddr),
        .s_axi_lite_arready_o (arready),
        .s_axi_lite_arvalid_i (arvalid),
        .s_axi_lite_awaddr_i  (awaddr),
        .s_axi_lite_awready_o (awready),
        .s_axi_lite_awvalid_i (awvalid),
        .s_axi_lite_bready_i  (bready),
        .s_axi_lite_bresp_o   (bresp),
        .s_axi_lite_bvalid_o  (bvalid),
        .s_axi_lite_rdata_o   (rdata),
        .s_axi_lite_rready_i  (rready),
        .s_axi_lite_rresp_o   (rresp),
        .s_axi_lite_rvalid_o  (rvalid),
        .s_axi_lite_wdata_i   (wdata),
        .s_axi_lite_wready_o  (wready),
        .s_axi_lite_wvalid_i  (wvalid),
        .out_stream_tdata_o   (tdata),
        .out_stream_tkeep_o   (tkeep),
        .out_stream_tlast_o   (tlast),
        .out_stream_tuser_o   (tuser),
        .out_stream_tvalid_o  (tvalid),
        .out_stream_tready_i  (tready)
    );

    `include "tb_model.svh"

    always #10 out_stream_aclk = ~out_stream_aclk;

    //////////////////////////////
    // reporting

    task automatic log_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        test_errors++;
    endtask

    task automatic note_failure(input string msg);
        $display("%s (at %0t ns)", msg, $time);
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    //////////////////////////////
    // pixel stream

    // raster order, real steps up along a row, imaginary steps down per row
    function automatic void build_frame(input int start_x, input int start_y, input int step);
        int re, im, n;
        im = start_y;
        for (int y = 0; y < 3; y++) begin
            re = start_x;
            for (int x = 0; x < 4; x++) begin
                n = escape_count(re, im, MAX_ITER);
                exp_data[y * 4 + x] = {8'h00, n[7:0], n[7:0], n[15:8]};
                re += step;
            end
            im -= step;
        end
    endfunction

    task automatic check_beat(input int count);
        int idx;
        idx = count % FRAME_PIXELS;
        assert (tdata == exp_data[idx])
            else log_mismatch($sformatf("beat %0d tdata %h, expected %h",
                                        count, tdata, exp_data[idx]));
        assert (tuser == (idx == 0))
            else log_mismatch($sformatf("beat %0d tuser %b", count, tuser));
        assert (tlast == (idx % 4 == 3))
            else log_mismatch($sformatf("beat %0d tlast %b", count, tlast));
        assert (tkeep == 4'hf)
            else log_mismatch($sformatf("beat %0d tkeep %h", count, tkeep));
    endtask

    task automatic take_beat(input bit rand_ready, inout int count);
        logic got;
        got = 1'b0;
        while (!got) begin
            tready = rand_ready ? ($urandom % 2 == 0) : 1'b1;
            if (tvalid && tready) begin
                check_beat(count);
                count++;
                got = 1'b1;
            end
            next_cycle();
        end
    endtask

    // clear run, then take beats until the stream has been quiet long enough
    task automatic stop_and_drain(input bit rand_ready, inout int count);
        logic [1:0] resp;
        int         idle, at_stop;
        tready = 1'b0;
        write_reg(8'(fractal_pkg::REG_CTRL * 4), 32'h0, 0, resp);
        assert (resp == fractal_pkg::RESP_OKAY)
            else log_mismatch($sformatf("run clear bresp %0d", resp));
        at_stop = count;
        idle    = 0;
        while (idle < IDLE_WAIT) begin
            tready = rand_ready ? ($urandom % 2 == 0) : 1'b1;
            if (tvalid) begin
                idle = 0;
                if (tready) begin
                    check_beat(count);
                    count++;
                end
            end else begin
                idle++;
            end
            next_cycle();
        end
        tready = 1'b0;
        assert (count % FRAME_PIXELS == 0)
            else note_failure($sformatf("stream stopped inside a frame after %0d beats", count));
        // eight cores already hold the next frame when its first beats go out
        assert (count - at_stop == FRAME_PIXELS)
            else note_failure($sformatf("%0d beats after run was cleared, not one frame",
                                        count - at_stop));
    endtask

    //////////////////////////////
    // directed tests

    task automatic register_access();
        logic [31:0] value;
        logic [1:0]  resp;
        reg_shadow[fractal_pkg::REG_CTRL]     = 32'h5a5a_5a5a;  // run bit clear
        reg_shadow[fractal_pkg::REG_START_X]  = 32'h1234_5678;
        reg_shadow[fractal_pkg::REG_START_Y]  = 32'h8765_4321;
        reg_shadow[fractal_pkg::REG_STEP]     = 32'h00ab_cdef;
        reg_shadow[fractal_pkg::REG_MAX_ITER] = 32'hdead_0014;
        reg_shadow[fractal_pkg::REG_SIZE]     = 32'h0042_0017;
        for (int i = 0; i < fractal_pkg::REG_COUNT; i++) begin
            write_reg(8'(i * 4), reg_shadow[i], i % 3, resp);
            assert (resp == fractal_pkg::RESP_OKAY)
                else log_mismatch($sformatf("write reg %0d bresp %0d", i, resp));
        end
        for (int i = 0; i < fractal_pkg::REG_COUNT; i++) begin
            read_reg(8'(i * 4), value, resp);
            assert (value == reg_shadow[i] && resp == fractal_pkg::RESP_OKAY)
                else log_mismatch($sformatf("reg %0d read %h resp %0d, expected %h",
                                            i, value, resp, reg_shadow[i]));
        end
        finish_test("register_access");
    endtask

    task automatic bad_address();
        logic [31:0] value;
        logic [1:0]  resp;
        write_reg(8'h1c, 32'hffff_ffff, 0, resp);
        assert (resp == fractal_pkg::RESP_SLVERR)
            else log_mismatch($sformatf("word 7 write bresp %0d", resp));
        write_reg(8'h20, 32'hffff_ffff, 1, resp);  // aliases word 0 without the upper check
        assert (resp == fractal_pkg::RESP_SLVERR)
            else log_mismatch($sformatf("word 8 write bresp %0d", resp));
        for (int i = 0; i < fractal_pkg::REG_COUNT; i++) begin
            read_reg(8'(i * 4), value, resp);
            assert (value == reg_shadow[i] && resp == fractal_pkg::RESP_OKAY)
                else log_mismatch($sformatf("reg %0d changed to %h", i, value));
        end
        read_reg(8'h1c, value, resp);
        assert (value == 32'h0 && resp == fractal_pkg::RESP_SLVERR)
            else log_mismatch($sformatf("word 7 read %h resp %0d", value, resp));
        finish_test("bad_address");
    endtask

    task automatic frame_ready_high();
        logic [1:0] resp;
        int         count;
        write_reg(8'(fractal_pkg::REG_START_X * 4), VIEW_X, 0, resp);
        write_reg(8'(fractal_pkg::REG_START_Y * 4), VIEW_Y, 1, resp);
        write_reg(8'(fractal_pkg::REG_STEP * 4), VIEW_STEP, 2, resp);
        write_reg(8'(fractal_pkg::REG_MAX_ITER * 4), 32'(MAX_ITER), 0, resp);
        write_reg(8'(fractal_pkg::REG_SIZE * 4), 32'h0003_0004, 0, resp);  // 3 rows of 4
        build_frame(VIEW_X, VIEW_Y, VIEW_STEP);
        write_reg(8'(fractal_pkg::REG_CTRL * 4), 32'h1, 0, resp);
        count = 0;
        repeat (FRAME_PIXELS) take_beat(1'b0, count);
        stop_and_drain(1'b0, count);
        finish_test("frame_ready_high");
    endtask

    task automatic frame_backpressure();
        logic [1:0] resp;
        int         count;
        write_reg(8'(fractal_pkg::REG_CTRL * 4), 32'h1, 0, resp);
        count = 0;
        repeat (FRAME_PIXELS) take_beat(1'b1, count);
        stop_and_drain(1'b1, count);
        finish_test("frame_backpressure");
    endtask

    task automatic back_to_back_frames();
        logic [1:0] resp;
        int         count;
        write_reg(8'(fractal_pkg::REG_CTRL * 4), 32'h1, 0, resp);
        count = 0;
        repeat (2 * FRAME_PIXELS) take_beat(1'b0, count);  // beat 13 opens frame two
        stop_and_drain(1'b0, count);
        finish_test("back_to_back_frames");
    endtask

    //////////////////////////////
    // run control

    initial begin
        void'($urandom(62));
        out_stream_aclk = 1'b0;
        axi_resetn      = 1'b0;
        araddr          = '0;
        arvalid         = 1'b0;
        awaddr          = '0;
        awvalid         = 1'b0;
        wdata           = '0;
        wvalid          = 1'b0;
        bready          = 1'b0;
        rready          = 1'b0;
        tready          = 1'b0;
        test_errors     = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        repeat (4) @(posedge out_stream_aclk);
        #2;
        axi_resetn = 1'b1;
        register_access();
        bad_address();
        frame_ready_high();
        frame_backpressure();
        back_to_back_frames();
        $display("summary: %0d tests passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge out_stream_aclk);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d clock cycles", cycle_count);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire
